// ==== src/main_bus_pkg.sv ====
/*
 * Main CPU bus definitions.
 * Region indices of the address mapper, its reset map and the data word
 * returned when nothing answers. Imported by the bus controller, the mapper
 * and the chip select block.
 */
package main_bus_pkg;

    // Mapper regions, one chip select group each
    localparam logic [2:0] REG_MEM = 3'd0;
    localparam logic [2:0] REG_SCR = 3'd1;
    localparam logic [2:0] REG_PAL = 3'd2;
    localparam logic [2:0] REG_OBJ = 3'd3;
    localparam logic [2:0] REG_IO  = 3'd4;
    localparam logic [2:0] REG_SUB = 3'd5;

    localparam int NUM_REGIONS = 6;

    localparam logic [15:0] BUS_IDLE_DATA = 16'hFFFF; // Open bus and bus error reads
    localparam logic [ 7:0] MAPPER_PAGE   = 8'hFF;    // A[23:16] of the mapper registers

    // Power-up map, indexed by region
    localparam logic [7:0] mapper_reset_base [NUM_REGIONS] = '{
        8'h00, 8'h10, 8'h14, 8'h15, 8'h16, 8'h20
    };
    localparam logic [7:0] mapper_reset_mask [NUM_REGIONS] = '{
        8'hF8, 8'hFE, 8'hFF, 8'hFF, 8'hFF, 8'hF0
    };

endpackage

// ==== src/cab_io_pkg.sv ====
/*
 * Cabinet I/O definitions.
 * Address groups of the I/O page, analog channel numbers and the control
 * word layout of the parallel port. Imported by cab_io and ppi_8255.
 */
package cab_io_pkg;

    localparam logic [2:0] IO_GRP_PPI    = 3'd0; // A[6:4]
    localparam logic [2:0] IO_GRP_INPUTS = 3'd1;
    localparam logic [2:0] IO_GRP_ADC    = 3'd3;

    localparam logic [2:0] ADC_STEER = 3'd0;
    localparam logic [2:0] ADC_GAS   = 3'd1;
    localparam logic [2:0] ADC_BRAKE = 3'd2;

    // Mode set, bit 7 high. Direction bits high mean input
    typedef struct packed {
        logic       mode_set;
        logic [1:0] mode_a;
        logic       dir_a;
        logic       dir_ch;  // Port C upper nibble
        logic       mode_b;
        logic       dir_b;
        logic       dir_cl;  // Port C lower nibble
    } ppi_mode_t;

    // Port C bit set/reset, bit 7 low
    typedef struct packed {
        logic       mode_set;
        logic [2:0] unused;
        logic [2:0] bit_sel;
        logic       bit_val;
    } ppi_bsr_t;

    typedef union packed {
        ppi_mode_t  mode;
        ppi_bsr_t   bsr;
        logic [7:0] raw;
    } ppi_ctrl_u;

endpackage

// ==== src/main_bus_if.sv ====
`timescale 1ns/10ps
/*
 * Internal main bus.
 * Driven by the bus controller for the length of one access. The mapper,
 * chip select and cabinet I/O blocks listen through the slave modport.
 */
interface main_bus_if;

    logic [23:1] addr;
    logic [15:0] wdata;
    logic        rnw;
    logic [ 1:0] dsn;     // {UDS, LDS}, active low
    logic        strobe;  // Address strobe, high during the access

    modport master (
        output addr, wdata, rnw, dsn, strobe
    );

    modport slave (
        input addr, wdata, rnw, dsn, strobe
    );

endinterface

// ==== src/region_mapper.sv ====
`timescale 1ns/10ps
/*
 * Programmable region mapper.
 * Each region has a base and a mask byte compared against A[23:16]; the
 * lowest matching region wins. Page FF holds the base/mask registers
 * themselves, so the CPU can move regions around at run time.
 */
module region_mapper (
    input  logic                                  clk,
    input  logic                                  rst,
    main_bus_if.slave                             bus,
    output logic [main_bus_pkg::NUM_REGIONS-1:0]  active,
    output logic                                  none_cs,
    output logic [15:0]                           mapper_dout
);
    import main_bus_pkg::*;

    logic [7:0]             base_r [NUM_REGIONS];
    logic [7:0]             mask_r [NUM_REGIONS];
    logic [NUM_REGIONS-1:0] match;
    logic [7:0]             page;
    logic [7:0]             rd_byte;
    logic [2:0]             reg_idx;
    logic                   map_hit;
    logic                   strobe_d;
    logic                   reg_wr;

    assign page    = bus.addr[23:16];
    assign map_hit = page == MAPPER_PAGE;
    assign reg_idx = bus.addr[4:2];   // A[1] picks base or mask
    // Second strobed edge only
    assign reg_wr  = bus.strobe && strobe_d && !bus.rnw && !bus.dsn[0] && map_hit;

    always_comb begin
        for (int r = 0; r < NUM_REGIONS; r++) begin
            match[r] = ((page ^ base_r[r]) & mask_r[r]) == 8'd0;
        end
    end

    // Keep only the lowest set bit
    assign active  = map_hit ? '0 : match & (~match + 1'b1);
    assign none_cs = map_hit || match == '0;

    always_comb begin
        rd_byte = 8'hFF;
        if (reg_idx < NUM_REGIONS) begin
            rd_byte = bus.addr[1] ? mask_r[reg_idx] : base_r[reg_idx];
        end
        mapper_dout = map_hit ? {8'hFF, rd_byte} : BUS_IDLE_DATA;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            strobe_d <= 1'b0;
            for (int r = 0; r < NUM_REGIONS; r++) begin
                base_r[r] <= mapper_reset_base[r];
                mask_r[r] <= mapper_reset_mask[r];
            end
        end else begin
            strobe_d <= bus.strobe;
            if (reg_wr && reg_idx < NUM_REGIONS) begin
                if (bus.addr[1]) begin
                    mask_r[reg_idx] <= bus.wdata[7:0];
                end else begin
                    base_r[reg_idx] <= bus.wdata[7:0];
                end
            end
        end
    end

endmodule

// ==== src/chip_select.sv ====
`timescale 1ns/10ps
/*
 * Registered chip selects.
 * Turns the active mapper region and a few address bits into one select
 * per device. Selects are sampled while the strobe is high and drop one
 * edge after it falls.
 */
module chip_select (
    input  logic                                 clk,
    input  logic                                 rst,
    main_bus_if.slave                            bus,
    input  logic [main_bus_pkg::NUM_REGIONS-1:0] active,
    output logic                                 rom_cs,
    output logic                                 ram_cs,
    output logic                                 vram_cs,
    output logic                                 char_cs,
    output logic                                 pal_cs,
    output logic                                 objram_cs,
    output logic                                 sub_cs,
    output logic                                 io_cs
);
    import main_bus_pkg::*;

    logic ds; // Any data strobe

    assign ds = bus.dsn != 2'b11;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {rom_cs, ram_cs, vram_cs, char_cs} <= '0;
            {pal_cs, objram_cs, sub_cs, io_cs} <= '0;
        end else if (bus.strobe) begin
            rom_cs    <= active[REG_MEM] && bus.addr[18:17] != 2'b11;
            ram_cs    <= active[REG_MEM] && bus.addr[18:17] == 2'b11 && ds; // 060000 up
            char_cs   <= active[REG_SCR] && bus.addr[16];
            vram_cs   <= active[REG_SCR] && !bus.addr[16] && ds;
            pal_cs    <= active[REG_PAL];
            objram_cs <= active[REG_OBJ];
            io_cs     <= active[REG_IO];
            sub_cs    <= active[REG_SUB];
        end else begin
            {rom_cs, ram_cs, vram_cs, char_cs} <= '0;
            {pal_cs, objram_cs, sub_cs, io_cs} <= '0;
        end
    end

    // Relies on the mapper never flagging two regions
    sel_onehot_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, sub_cs, io_cs}));

endmodule

// ==== src/ppi_8255.sv ====
`timescale 1ns/10ps
/*
 * 8255-style parallel port, mode 0 only.
 * Three output latches and a control register. Offset 3 takes either a
 * mode-set word, which clears the latches, or a port C bit set/reset.
 * Ports set as inputs float high on the outputs.
 */
module ppi_8255 (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    input  logic       wr,
    input  logic       rd_sel,    // Port chip select
    output logic [7:0] dout,
    output logic [7:0] porta_out,
    output logic [7:0] portb_out,
    output logic [7:0] portc_out
);
    import cab_io_pkg::*;

    logic [7:0] porta_r;
    logic [7:0] portb_r;
    logic [7:0] portc_r;
    ppi_ctrl_u  ctrl_r;
    ppi_ctrl_u  ctrl_w;

    assign ctrl_w = ppi_ctrl_u'(din);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            porta_r    <= 8'd0;
            portb_r    <= 8'd0;
            portc_r    <= 8'd0;
            ctrl_r.raw <= 8'h80;  // Mode 0, all ports out
        end else if (wr) begin
            case (addr)
                2'd0: porta_r <= din;
                2'd1: portb_r <= din;
                2'd2: portc_r <= din;
                2'd3: begin
                    if (ctrl_w.mode.mode_set) begin
                        ctrl_r  <= ctrl_w;
                        porta_r <= 8'd0;
                        portb_r <= 8'd0;
                        portc_r <= 8'd0;
                    end else begin
                        portc_r[ctrl_w.bsr.bit_sel] <= ctrl_w.bsr.bit_val;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr)
            2'd0:    dout = porta_r;
            2'd1:    dout = portb_r;
            2'd2:    dout = portc_r;
            default: dout = 8'hFF;
        endcase
        if (!rd_sel) dout = 8'hFF;
    end

    assign porta_out = ctrl_r.mode.dir_a ? 8'hFF : porta_r;
    assign portb_out = ctrl_r.mode.dir_b ? 8'hFF : portb_r;
    assign portc_out = {ctrl_r.mode.dir_ch ? 4'hF : portc_r[7:4],
                        ctrl_r.mode.dir_cl ? 4'hF : portc_r[3:0]};

    wr_cs_a: assert property (@(posedge clk) disable iff (rst) wr |-> rd_sel);

endmodule

// ==== src/cab_io.sv ====
`timescale 1ns/10ps
/*
 * Cabinet I/O page.
 * Address bits 6:4 pick the parallel port, the digital inputs or the
 * analog channel chosen through port A. Port A also carries the video
 * enable and object configuration bits.
 */
module cab_io (
    input  logic        clk,
    input  logic        rst,
    main_bus_if.slave   bus,
    input  logic        io_cs,
    input  logic [ 7:0] joystick1,
    input  logic [ 1:0] start_button,
    input  logic [ 1:0] coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [ 7:0] dipsw_a,
    input  logic [ 7:0] dipsw_b,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana2,
    output logic [ 7:0] io_dout,
    output logic        video_en,
    output logic [ 1:0] obj_cfg
);
    import cab_io_pkg::*;

    logic [2:0] grp;
    logic [2:0] adc_ch;
    logic [7:0] ppi_dout;
    logic [7:0] porta;
    logic       ppi_sel;

    assign grp      = bus.addr[6:4];
    assign ppi_sel  = io_cs && grp == IO_GRP_PPI;
    assign obj_cfg  = porta[7:6];
    assign video_en = porta[5];
    assign adc_ch   = porta[4:2];

    always_comb begin
        io_dout = 8'hFF;
        if (io_cs) begin
            case (grp)
                IO_GRP_PPI: io_dout = ppi_dout;
                IO_GRP_INPUTS: begin
                    case (bus.addr[2:1])
                        2'd0: io_dout = {coin_input, 1'b0, joystick1[4], start_button[0],
                                         service, dip_test, 1'b1};
                        2'd2: io_dout = dipsw_a;
                        2'd3: io_dout = dipsw_b;
                        default: io_dout = 8'hFF;
                    endcase
                end
                IO_GRP_ADC: begin
                    case (adc_ch)
                        ADC_STEER: io_dout = joyana1[7:0];
                        ADC_GAS:   io_dout = joyana1[15:8] + 8'h80; // Pedals centred at 0
                        ADC_BRAKE: io_dout = joyana2[15:8] + 8'h80;
                        default:   io_dout = 8'hFF;
                    endcase
                end
                default: io_dout = 8'hFF;
            endcase
        end
    end

    ppi_8255 u_ppi (
        .clk       (clk),
        .rst       (rst),
        .addr      (bus.addr[2:1]),
        .din       (bus.wdata[7:0]),
        .wr        (ppi_sel && bus.strobe && !bus.rnw && !bus.dsn[0]),
        .rd_sel    (ppi_sel),
        .dout      (ppi_dout),
        .porta_out (porta),
        .portb_out (),
        .portc_out ()
    );

endmodule

// ==== src/bus_ctrl.sv ====
`timescale 1ns/10ps
/*
 * Main bus controller.
 * Accepts one valid/ready request from idle, drives the internal bus and
 * waits for the device. Video, I/O and mapper reads finish at the second
 * edge after acceptance; ROM, RAM and sub wait for their ok, and end in a
 * bus error after WAIT_LIMIT cycles without it.
 */
module bus_ctrl #(
    parameter int WAIT_LIMIT = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_valid,
    input  logic [23:1] cpu_addr,
    input  logic        cpu_rnw,
    input  logic [ 1:0] cpu_dsn,
    input  logic [15:0] cpu_wdata,
    output logic        cpu_ready,
    output logic [15:0] cpu_rdata,
    output logic        cpu_berr,
    input  logic        rom_cs,
    input  logic        ram_cs,
    input  logic        vram_cs,
    input  logic        sub_cs,
    input  logic        char_cs,
    input  logic        pal_cs,
    input  logic        objram_cs,
    input  logic        io_cs,
    input  logic        none_cs,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    input  logic [15:0] ram_data,   // RAM or VRAM
    input  logic        ram_ok,
    input  logic [15:0] sub_din,
    input  logic        sub_ok,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] mapper_dout,
    input  logic [ 7:0] io_dout,
    main_bus_if.master  bus
);
    import main_bus_pkg::*;

    localparam int CW = $clog2(WAIT_LIMIT + 1);

    typedef enum logic [1:0] { ST_IDLE, ST_STRB, ST_WAIT } state_t;

    state_t        state;
    logic [CW-1:0] wait_cnt;
    logic          accept, fixed_acc, ext_done, timeout;
    logic [15:0]   rd_mux;

    assign accept    = state == ST_IDLE && cpu_valid && !cpu_ready;
    assign fixed_acc = char_cs | pal_cs | objram_cs | io_cs | none_cs;
    assign ext_done  = (rom_cs & rom_ok) | ((ram_cs | vram_cs) & ram_ok) | (sub_cs & sub_ok);
    assign timeout   = wait_cnt == CW'(WAIT_LIMIT - 1);

    assign rd_mux = (ram_cs | vram_cs) ? ram_data  :
                    rom_cs             ? rom_data  :
                    char_cs            ? char_dout :
                    pal_cs             ? pal_dout  :
                    objram_cs          ? obj_dout  :
                    sub_cs             ? sub_din   :
                    io_cs              ? {8'hFF, io_dout} :
                    none_cs            ? mapper_dout : BUS_IDLE_DATA;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            bus.strobe <= 1'b0;
            cpu_ready  <= 1'b0;
            cpu_berr   <= 1'b0;
            wait_cnt   <= '0;
        end else begin
            cpu_ready <= 1'b0;
            case (state)
                ST_IDLE: if (accept) begin
                    state      <= ST_STRB;
                    bus.strobe <= 1'b1;
                    wait_cnt   <= '0;
                end
                ST_STRB: state <= ST_WAIT;  // Selects register here
                ST_WAIT: begin
                    if (fixed_acc || ext_done || timeout) begin
                        state      <= ST_IDLE;
                        bus.strobe <= 1'b0;
                        cpu_ready  <= 1'b1;
                        cpu_berr   <= !(fixed_acc || ext_done);
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus.addr  <= cpu_addr;
            bus.wdata <= cpu_wdata;
            bus.rnw   <= cpu_rnw;
            bus.dsn   <= cpu_dsn;
        end
        if (state == ST_WAIT) begin
            cpu_rdata <= (fixed_acc || ext_done) ? rd_mux : BUS_IDLE_DATA;
        end
    end

    req_stable_a: assert property (@(posedge clk) disable iff (rst)
        cpu_valid && !cpu_ready |=>
            cpu_valid && $stable({cpu_addr, cpu_rnw, cpu_dsn, cpu_wdata}));

    ready_pulse_a: assert property (@(posedge clk) disable iff (rst)
        cpu_ready |=> !cpu_ready);

endmodule

// ==== src/main_top.sv ====
`timescale 1ns/10ps
/*
 * Main CPU bus glue, top level.
 * The CPU side is a valid/ready request port; the device side is the
 * board's chip select and ok signals. Blocks share the internal bus.
 * WAIT_LIMIT bounds how long ROM, RAM and sub may stall.
 */
module main_top #(
    parameter int WAIT_LIMIT = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_valid,
    input  logic [23:1] cpu_addr,
    input  logic        cpu_rnw,
    input  logic [ 1:0] cpu_dsn,
    input  logic [15:0] cpu_wdata,
    output logic        cpu_ready,
    output logic [15:0] cpu_rdata,
    output logic        cpu_berr,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        pal_cs,
    output logic        objram_cs,
    output logic        sub_cs,
    output logic [19:1] addr,
    output logic [15:0] bus_wdata,
    output logic        bus_rnw,
    output logic [ 1:0] bus_dsn,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    input  logic [15:0] ram_data,
    input  logic        ram_ok,
    input  logic [15:0] sub_din,
    input  logic        sub_ok,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [ 7:0] joystick1,
    input  logic [ 1:0] start_button,
    input  logic [ 1:0] coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [ 7:0] dipsw_a,
    input  logic [ 7:0] dipsw_b,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana2,
    output logic        video_en,
    output logic [ 1:0] obj_cfg
);
    import main_bus_pkg::*;

    main_bus_if bus ();

    logic [NUM_REGIONS-1:0] active;
    logic                   none_cs;
    logic                   io_cs;
    logic [15:0]            mapper_dout;
    logic [ 7:0]            io_dout;

    assign addr      = bus.addr[19:1];
    assign bus_wdata = bus.wdata;
    assign bus_rnw   = bus.rnw;
    assign bus_dsn   = bus.dsn;

    bus_ctrl #(.WAIT_LIMIT(WAIT_LIMIT)) u_ctrl (
        .clk, .rst, .cpu_valid, .cpu_addr, .cpu_rnw, .cpu_dsn, .cpu_wdata,
        .cpu_ready, .cpu_rdata, .cpu_berr,
        .rom_cs, .ram_cs, .vram_cs, .sub_cs, .char_cs, .pal_cs, .objram_cs,
        .io_cs, .none_cs,
        .rom_data, .rom_ok, .ram_data, .ram_ok, .sub_din, .sub_ok,
        .char_dout, .pal_dout, .obj_dout, .mapper_dout, .io_dout,
        .bus (bus.master)
    );

    region_mapper u_mapper (
        .clk, .rst, .bus (bus.slave), .active, .none_cs, .mapper_dout
    );

    chip_select u_cs (
        .clk, .rst, .bus (bus.slave), .active,
        .rom_cs, .ram_cs, .vram_cs, .char_cs, .pal_cs, .objram_cs, .sub_cs, .io_cs
    );

    cab_io u_cab (
        .clk, .rst, .bus (bus.slave), .io_cs,
        .joystick1, .start_button, .coin_input, .service, .dip_test,
        .dipsw_a, .dipsw_b, .joyana1, .joyana2,
        .io_dout, .video_en, .obj_cfg
    );

endmodule

// ==== verif/main_tb.sv ====
`timescale 1ns/10ps
/*
 * Directed testbench for the main CPU bus glue.
 * Plays the CPU through the valid/ready port, models ROM, RAM, sub CPU
 * and video devices, and checks read data, chip selects and cabinet I/O.
 */
module main_tb;
    import main_bus_pkg::*;
    import cab_io_pkg::*;

    localparam int WAIT_LIMIT      = 16;
    localparam int RST_CYCLES      = 8;
    localparam int ACCESS_LIMIT    = 64;  // Cycles one access may take
    localparam int NUM_ACCESSES    = 64;  // Generous bound on accesses in the run
    localparam int WATCHDOG_CYCLES = RST_CYCLES + NUM_ACCESSES * (WAIT_LIMIT + 8);

    // Bit positions in the select snapshot
    localparam int CS_ROM  = 6;
    localparam int CS_RAM  = 5;
    localparam int CS_VRAM = 4;
    localparam int CS_CHAR = 3;
    localparam int CS_PAL  = 2;
    localparam int CS_OBJ  = 1;
    localparam int CS_SUB  = 0;

    logic        clk;
    logic        rst;
    logic        cpu_valid;
    logic [23:1] cpu_addr;
    logic        cpu_rnw;
    logic [ 1:0] cpu_dsn;
    logic [15:0] cpu_wdata;
    logic        cpu_ready;
    logic [15:0] cpu_rdata;
    logic        cpu_berr;
    logic        rom_cs;
    logic        ram_cs;
    logic        vram_cs;
    logic        char_cs;
    logic        pal_cs;
    logic        objram_cs;
    logic        sub_cs;
    logic [19:1] addr;
    logic [15:0] bus_wdata;
    logic        bus_rnw;
    logic [ 1:0] bus_dsn;
    logic [15:0] rom_data;
    logic        rom_ok;
    logic [15:0] ram_data;
    logic        ram_ok;
    logic [15:0] sub_din;
    logic        sub_ok;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [ 7:0] joystick1;
    logic [ 1:0] start_button;
    logic [ 1:0] coin_input;
    logic        service;
    logic        dip_test;
    logic [ 7:0] dipsw_a;
    logic [ 7:0] dipsw_b;
    logic [15:0] joyana1;
    logic [15:0] joyana2;
    logic        video_en;
    logic [ 1:0] obj_cfg;

    logic [15:0] ram_mem [256];
    logic [ 2:0] sub_delay;
    logic [ 4:0] sub_cnt;
    logic [31:0] rng_state;
    logic [15:0] last_rdata;
    logic        last_berr;
    int          last_edges;
    logic [ 6:0] last_cs;   // Selects seen during the last access
    int          errors;
    int          checks;

    main_top #(.WAIT_LIMIT(WAIT_LIMIT)) DUT (.*);

    always #10 clk = ~clk;

    // Device models
    assign rom_data  = addr[16:1] ^ 16'h5A5A;
    assign rom_ok    = rom_cs;
    assign ram_data  = ram_mem[addr[8:1]];
    assign ram_ok    = ram_cs | vram_cs;
    assign char_dout = addr[16:1] ^ 16'hC4A2;
    assign pal_dout  = addr[16:1] ^ 16'h9A11;
    assign obj_dout  = addr[16:1] ^ 16'h0B1E;
    assign sub_ok    = sub_cs && !addr[19] && sub_cnt >= {2'b00, sub_delay}; // Dead above 0x80000

    always @(posedge clk) begin
        if (rst) begin
            sub_cnt <= '0;
            for (int i = 0; i < 256; i++) begin
                ram_mem[i] <= {8'(i), ~8'(i)};
            end
        end else begin
            sub_cnt <= sub_cs ? sub_cnt + 5'd1 : 5'd0;
            if ((ram_cs || vram_cs) && !bus_rnw) begin
                if (!bus_dsn[1]) ram_mem[addr[8:1]][15:8] <= bus_wdata[15:8];
                if (!bus_dsn[0]) ram_mem[addr[8:1]][7:0]  <= bus_wdata[7:0];
            end
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // One request through the valid/ready port, results in last_*
    task automatic bus_access(input logic [23:0] byte_addr, input logic rnw,
                              input logic [1:0] dsn, input logic [15:0] wdata);
        @(posedge clk);
        #2;
        cpu_valid  = 1'b1;
        cpu_addr   = byte_addr[23:1];
        cpu_rnw    = rnw;
        cpu_dsn    = dsn;
        cpu_wdata  = wdata;
        last_edges = 0;
        last_cs    = '0;
        last_rdata = 16'hxxxx;
        last_berr  = 1'bx;
        do begin
            @(posedge clk);
            #1;
            last_edges++;
            last_cs |= {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, sub_cs};
        end while (!cpu_ready && last_edges < ACCESS_LIMIT);
        if (cpu_ready) begin
            last_rdata = cpu_rdata;
            last_berr  = cpu_berr;
        end else begin
            errors++;
            $display("No cpu_ready within %0d cycles for address %h", ACCESS_LIMIT, byte_addr);
        end
        // Request stays up until the edge that sees ready
        @(posedge clk);
        #2;
        cpu_valid = 1'b0;
    endtask

    task automatic read_word(input logic [23:0] a);
        bus_access(a, 1'b1, 2'b00, 16'h0000);
    endtask

    task automatic write_word(input logic [23:0] a, input logic [15:0] d, input logic [1:0] dsn);
        bus_access(a, 1'b0, dsn, d);
    endtask

    task automatic reset_and_rom_read();
        check_word("selects", 16'({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, sub_cs}),
                   16'd0);
        check_word("cpu_ready", 16'(cpu_ready), 16'd0);
        check_word("cpu_berr", 16'(cpu_berr), 16'd0);
        check_word("video_en", 16'(video_en), 16'd0);
        check_word("obj_cfg", 16'(obj_cfg), 16'd0);
        read_word(24'h001234);
        check_word("cpu_rdata", last_rdata, 16'h091A ^ 16'h5A5A);
        check_word("cpu_berr", 16'(last_berr), 16'd0);
        check_word("rom_cs", 16'(last_cs[CS_ROM]), 16'd1);
        check_word("ram_cs", 16'(last_cs[CS_RAM]), 16'd0);
    endtask

    task automatic ram_and_video_access();
        write_word(24'h060010, 16'hBEEF, 2'b00);
        check_word("ram_cs", 16'(last_cs[CS_RAM]), 16'd1);
        write_word(24'h060010, 16'h0012, 2'b10);  // Low byte only
        read_word(24'h060010);
        check_word("cpu_rdata", last_rdata, 16'hBE12);
        read_word(24'h060012);
        check_word("cpu_rdata", last_rdata, 16'h09F6); // Untouched fill word
        read_word(24'h110020);
        check_word("char_cs", 16'(last_cs[CS_CHAR]), 16'd1);
        check_word("cpu_rdata", last_rdata, 16'h8010 ^ 16'hC4A2);
        check_word("cpu_ready latency", 16'(last_edges), 16'd3);
        read_word(24'h150010);
        check_word("objram_cs", 16'(last_cs[CS_OBJ]), 16'd1);
        check_word("cpu_rdata", last_rdata, 16'h8008 ^ 16'h0B1E);
        write_word(24'h100040, 16'h7E57, 2'b00);
        read_word(24'h100040);
        check_word("vram_cs", 16'(last_cs[CS_VRAM]), 16'd1);
        check_word("char_cs", 16'(last_cs[CS_CHAR]), 16'd0);
        check_word("cpu_rdata", last_rdata, 16'h7E57);
    endtask

    task automatic cabinet_inputs();
        read_word(24'h160010);
        check_word("cpu_rdata", last_rdata, 16'hFF9D); // Coin 2, P1 button, start 1, service
        read_word(24'h160012);
        check_word("cpu_rdata", last_rdata, 16'hFFFF);
        read_word(24'h160014);
        check_word("cpu_rdata", last_rdata, {8'hFF, dipsw_a});
        read_word(24'h160016);
        check_word("cpu_rdata", last_rdata, {8'hFF, dipsw_b});
        read_word(24'h160020);
        check_word("cpu_rdata", last_rdata, 16'hFFFF);
    endtask

    task automatic ppi_and_analog();
        logic [7:0] exp_ch [3];
        exp_ch[ADC_STEER] = 8'h5A;  // Low byte of joyana1
        exp_ch[ADC_GAS]   = 8'hBC;
        exp_ch[ADC_BRAKE] = 8'h11;
        write_word(24'h160000, 16'h0020, 2'b10);
        check_word("video_en", 16'(video_en), 16'd1);
        write_word(24'h160006, 16'h0080, 2'b10);  // Mode set clears the latches
        check_word("video_en", 16'(video_en), 16'd0);
        read_word(24'h160000);
        check_word("cpu_rdata", last_rdata, 16'hFF00);
        for (int ch = 0; ch < 3; ch++) begin
            write_word(24'h160000, {8'h00, 2'b10, 1'b1, 3'(ch), 2'b00}, 2'b10);
            check_word("video_en", 16'(video_en), 16'd1);
            check_word("obj_cfg", 16'(obj_cfg), 16'd2);
            read_word(24'h160030);
            check_word("cpu_rdata", last_rdata, {8'hFF, exp_ch[ch]});
        end
        write_word(24'h160004, 16'h005A, 2'b10);
        write_word(24'h160006, 16'h0005, 2'b10);  // Set bit 2
        read_word(24'h160004);
        check_word("cpu_rdata", last_rdata, 16'hFF5E);
        write_word(24'h160006, 16'h000C, 2'b10);  // Clear bit 6
        read_word(24'h160004);
        check_word("cpu_rdata", last_rdata, 16'hFF1E);
    endtask

    task automatic mapper_move();
        write_word({MAPPER_PAGE, 11'd0, REG_PAL, 2'b00}, 16'h0030, 2'b10);
        read_word({MAPPER_PAGE, 11'd0, REG_PAL, 2'b00});
        check_word("cpu_rdata", last_rdata, 16'hFF30);
        read_word(24'h300010);
        check_word("pal_cs", 16'(last_cs[CS_PAL]), 16'd1);
        check_word("cpu_rdata", last_rdata, 16'h0008 ^ 16'h9A11);
        read_word(24'h140010);
        check_word("selects", 16'(last_cs), 16'd0);
        check_word("cpu_rdata", last_rdata, BUS_IDLE_DATA);
        check_word("cpu_berr", 16'(last_berr), 16'd0);
    endtask

    task automatic sub_wait_and_berr();
        read_word(24'h280000);
        check_word("cpu_berr", 16'(last_berr), 16'd1);
        check_word("cpu_rdata", last_rdata, 16'hFFFF);
        check_word("cpu_ready latency", 16'(last_edges), 16'(WAIT_LIMIT + 2));
        for (int i = 0; i < 4; i++) begin
            rng_state = next_random(rng_state);
            sub_delay = rng_state[2:0];
            sub_din   = rng_state[31:16];
            read_word(24'h200100 + 24'(i * 2));
            check_word("sub_cs", 16'(last_cs[CS_SUB]), 16'd1);
            check_word("cpu_berr", 16'(last_berr), 16'd0);
            check_word("cpu_rdata", last_rdata, sub_din);
            check_word("cpu_ready latency", 16'(last_edges), 16'(3 + sub_delay));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        errors       = 0;
        checks       = 0;
        rng_state    = 32'ha573f90f;
        cpu_valid    = 1'b0;
        cpu_addr     = '0;
        cpu_rnw      = 1'b1;
        cpu_dsn      = 2'b11;
        cpu_wdata    = 16'h0000;
        sub_din      = 16'h0000;
        sub_delay    = 3'd0;
        joystick1    = 8'h10;
        start_button = 2'b01;
        coin_input   = 2'b10;
        service      = 1'b1;
        dip_test     = 1'b0;
        dipsw_a      = 8'hA5;
        dipsw_b      = 8'h3C;
        joyana1      = 16'h3C5A;
        joyana2      = 16'h9121;  // Brake wraps past FF
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_and_rom_read();
        ram_and_video_access();
        cabinet_inputs();
        ppi_and_analog();
        mapper_move();
        sub_wait_and_berr();
        $display("Run finished with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/main_bus_pkg.sv
src/cab_io_pkg.sv
src/main_bus_if.sv
src/region_mapper.sv
src/chip_select.sv
src/ppi_8255.sv
src/cab_io.sv
src/bus_ctrl.sv
src/main_top.sv
verif/main_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module main_tb \
    -Mdir obj_dir -o main_tb_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/main_tb_sim > sim.log 2>&1
cat sim.log

grep -q "^TEST OK$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
